/* design/pcie_cfg_pkg.sv */
// Shared widths, register map offsets, default values and the management FSM states

package pcie_cfg_pkg;

    // ------------------------------
    // Data types
    // ------------------------------
    typedef logic [63:0] cmd_word_t;    // Command word from the host side
    typedef logic [31:0] rsp_word_t;    // Address in upper half, data in lower half
    typedef logic [15:0] word16_t;
    typedef logic [15:0] byte_addr_t;   // Bit 15 selects the read-write map
    typedef logic [31:0] dword_t;
    typedef logic [9:0]  dwaddr_t;      // Config space dword address
    typedef logic [3:0]  byte_en_t;

    typedef enum logic [1:0] {IDLE, READ, WRITE} mgmt_state_t;

    // Command word fields
    localparam int CMD_BIT_RD      = 12;
    localparam int CMD_BIT_WR      = 13;
    localparam int ADDR_BIT_RW_MAP = 15;

    // Map sizes and identification
    localparam int      RW_MAP_BITS = 256;
    localparam int      RO_MAP_BITS = 192;
    localparam word16_t RW_MAGIC    = 16'h6745;
    localparam word16_t RO_MAGIC    = 16'h2301;

    localparam dword_t      CLEAR_INTERVAL_DEFAULT = 32'd62500;   // 1 ms of clk_pcie
    localparam logic [63:0] DSN_DEFAULT            = 64'h0000000101000A35;
    localparam byte_en_t    BYTE_EN_DEFAULT        = 4'hf;

    // ------------------------------
    // Read-write map bit positions
    // ------------------------------
    localparam int RW_POS_MAGIC           = 0;
    localparam int RW_POS_CFG_RD_EN       = 16;
    localparam int RW_POS_CFG_WR_EN       = 17;
    localparam int RW_POS_WAIT_COMPLETE   = 18;
    localparam int RW_POS_STATUS_CLEAR_EN = 19;
    localparam int RW_POS_BYTE_COUNT      = 32;
    localparam int RW_POS_DSN             = 64;
    localparam int RW_POS_MGMT_DI         = 128;
    localparam int RW_POS_MGMT_DWADDR     = 160;
    localparam int RW_POS_WR_READONLY     = 170;
    localparam int RW_POS_WR_RW1C         = 171;
    localparam int RW_POS_MGMT_BYTE_EN    = 172;
    localparam int RW_POS_CLEAR_INTERVAL  = 192;

    // Read-only map bit positions
    localparam int RO_POS_MAGIC       = 0;
    localparam int RO_POS_SPECIAL     = 16;
    localparam int RO_POS_BYTE_COUNT  = 32;
    localparam int RO_POS_FUNC_ID     = 64;
    localparam int RO_POS_LINK_STATUS = 80;
    localparam int RO_POS_MGMT_DO     = 96;
    localparam int RO_POS_READBACK    = 128;
    localparam int RO_POS_RB_DATA     = 160;

    // Status register error flag clear, written by the auto-clear timer
    localparam dword_t   CLEAR_DI      = 32'hff000000;
    localparam dwaddr_t  CLEAR_DWADDR  = 10'd1;
    localparam byte_en_t CLEAR_BYTE_EN = 4'b1000;

endpackage

/* design/cfg_rw_regs.sv */
// Read-write control register map with masked writes, start-bit clearing and clear load

`timescale 1ns/1ps

module cfg_rw_regs
    import pcie_cfg_pkg::*;
#(
    parameter dword_t CLEAR_INTERVAL = CLEAR_INTERVAL_DEFAULT
)
(
    input  logic                   clk_pcie,
    input  logic                   rst,
    input  logic                   i_wr_strobe,
    input  byte_addr_t             i_wr_addr,
    input  word16_t                i_wr_mask,
    input  word16_t                i_wr_value,
    input  logic                   i_clear_rd_start,
    input  logic                   i_clear_wr_start,
    input  logic                   i_clear_load,
    output logic [RW_MAP_BITS-1:0] o_rw_map,
    output logic                   o_start_rd,
    output logic                   o_start_wr,
    output logic                   o_wait_complete,
    output logic                   o_clear_en,
    output dword_t                 o_clear_interval,
    output logic [63:0]            o_dsn,
    output dword_t                 o_mgmt_di,
    output dwaddr_t                o_mgmt_dwaddr,
    output logic                   o_mgmt_wr_readonly,
    output logic                   o_mgmt_wr_rw1c,
    output byte_en_t               o_mgmt_byte_en
);

    logic [17:0] wr_bit;    // Bit offset of the addressed 16-bit word

    assign wr_bit = {i_wr_addr[14:0], 3'b000};

    // ------------------------------
    // Map storage
    // ------------------------------
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            o_rw_map                                <= '0;
            o_rw_map[RW_POS_MAGIC +: 16]            <= RW_MAGIC;
            o_rw_map[RW_POS_BYTE_COUNT +: 32]       <= 32'(RW_MAP_BITS / 8);
            o_rw_map[RW_POS_DSN +: 64]              <= DSN_DEFAULT;
            o_rw_map[RW_POS_MGMT_BYTE_EN +: 4]      <= BYTE_EN_DEFAULT;
            o_rw_map[RW_POS_CLEAR_INTERVAL +: 32]   <= CLEAR_INTERVAL;
        end
        else
        begin
            if (i_wr_strobe)
            begin
                for (int i = 0; i < 16; i++)
                begin
                    // Bits past the end of the map are dropped
                    if (i_wr_mask[i] && (int'(wr_bit) + i < RW_MAP_BITS))
                        o_rw_map[int'(wr_bit) + i] <= i_wr_value[i];
                end
            end

            // Sequencer and timer win over a command write
            if (i_clear_rd_start)
                o_rw_map[RW_POS_CFG_RD_EN] <= 1'b0;
            if (i_clear_wr_start)
                o_rw_map[RW_POS_CFG_WR_EN] <= 1'b0;

            if (i_clear_load)
            begin
                o_rw_map[RW_POS_CFG_WR_EN]          <= 1'b1;    // Launch the clear write
                o_rw_map[RW_POS_MGMT_DI +: 32]      <= CLEAR_DI;
                o_rw_map[RW_POS_MGMT_DWADDR +: 10]  <= CLEAR_DWADDR;
                o_rw_map[RW_POS_WR_READONLY]        <= 1'b0;
                o_rw_map[RW_POS_WR_RW1C]            <= 1'b0;
                o_rw_map[RW_POS_MGMT_BYTE_EN +: 4]  <= CLEAR_BYTE_EN;
            end
        end
    end

    // ------------------------------
    // Field decode
    // ------------------------------
    assign o_start_rd         = o_rw_map[RW_POS_CFG_RD_EN];
    assign o_start_wr         = o_rw_map[RW_POS_CFG_WR_EN];
    assign o_wait_complete    = o_rw_map[RW_POS_WAIT_COMPLETE];
    assign o_clear_en         = o_rw_map[RW_POS_STATUS_CLEAR_EN];
    assign o_clear_interval   = o_rw_map[RW_POS_CLEAR_INTERVAL +: 32];
    assign o_dsn              = o_rw_map[RW_POS_DSN +: 64];
    assign o_mgmt_di          = o_rw_map[RW_POS_MGMT_DI +: 32];
    assign o_mgmt_dwaddr      = o_rw_map[RW_POS_MGMT_DWADDR +: 10];
    assign o_mgmt_wr_readonly = o_rw_map[RW_POS_WR_READONLY];
    assign o_mgmt_wr_rw1c     = o_rw_map[RW_POS_WR_RW1C];
    assign o_mgmt_byte_en     = o_rw_map[RW_POS_MGMT_BYTE_EN +: 4];

endmodule

/* design/cfg_ro_status.sv */
// Read-only status map, config readback capture and read data selection for both maps

`timescale 1ns/1ps

module cfg_ro_status
    import pcie_cfg_pkg::*;
(
    input  logic                   clk_pcie,
    input  logic                   rst,
    input  logic [RW_MAP_BITS-1:0] i_rw_map,
    input  byte_addr_t             i_read_addr,
    input  word16_t                i_func_id,
    input  word16_t                i_link_status,
    input  logic                   i_mgmt_rd_en,
    input  logic                   i_mgmt_wr_en,
    input  dword_t                 i_mgmt_do,
    input  logic                   i_capture,
    input  dwaddr_t                i_mgmt_dwaddr,
    input  byte_en_t               i_mgmt_byte_en,
    output word16_t                o_read_data
);

    logic [RO_MAP_BITS-1:0]    ro_map;
    logic                      rb_valid;
    dwaddr_t                   rb_dwaddr;
    byte_en_t                  rb_byte_en;
    dword_t                    rb_data;
    logic [17:0]               rd_bit;
    logic [RW_MAP_BITS+15:0]   rw_ext;      // Zero padded so a word may straddle the end
    logic [RO_MAP_BITS+15:0]   ro_ext;

    // Readback of the last completed access
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            rb_valid <= 1'b0;
        else if (i_capture)
            rb_valid <= 1'b1;
        else if (i_mgmt_rd_en || i_mgmt_wr_en)
            rb_valid <= 1'b0;   // New access in flight
    end

    always_ff @(posedge clk_pcie)
    begin
        if (i_capture)
        begin
            rb_dwaddr  <= i_mgmt_dwaddr;
            rb_byte_en <= i_mgmt_byte_en;
            rb_data    <= i_mgmt_do;
        end
    end

    // ------------------------------
    // Map assembly
    // ------------------------------
    assign ro_map[RO_POS_MAGIC +: 16]       = RO_MAGIC;
    assign ro_map[RO_POS_SPECIAL +: 16]     = {14'd0, i_mgmt_wr_en, i_mgmt_rd_en};
    assign ro_map[RO_POS_BYTE_COUNT +: 32]  = 32'(RO_MAP_BITS / 8);
    assign ro_map[RO_POS_FUNC_ID +: 16]     = i_func_id;
    assign ro_map[RO_POS_LINK_STATUS +: 16] = i_link_status;
    assign ro_map[RO_POS_MGMT_DO +: 32]     = i_mgmt_do;
    assign ro_map[RO_POS_READBACK +: 32]    = {16'd0, rb_byte_en, rb_valid, 1'b0, rb_dwaddr};
    assign ro_map[RO_POS_RB_DATA +: 32]     = rb_data;

    // Word select
    assign rd_bit = {i_read_addr[14:0], 3'b000};
    assign rw_ext = {16'd0, i_rw_map};
    assign ro_ext = {16'd0, ro_map};

    always_comb
    begin
        o_read_data = '0;   // Beyond the end of either map
        if (i_read_addr[ADDR_BIT_RW_MAP])
        begin
            if (int'(rd_bit) < RW_MAP_BITS)
                o_read_data = rw_ext[rd_bit[7:0] +: 16];
        end
        else if (int'(rd_bit) < RO_MAP_BITS)
            o_read_data = ro_ext[rd_bit[7:0] +: 16];
    end

endmodule

/* design/cfg_status_clear.sv */
// Auto-clear interval counter requesting the status register clear write

`timescale 1ns/1ps

module cfg_status_clear
    import pcie_cfg_pkg::*;
(
    input  logic   clk_pcie,
    input  logic   rst,
    input  logic   i_enable,
    input  logic   i_idle,
    input  dword_t i_interval,
    output logic   o_load
);

    dword_t count;  // Idle cycles since the last clear
    logic   step;

    assign step = i_enable & i_idle;

    // A lowered interval must not leave the counter stranded above it
    assign o_load = step & (count >= i_interval);

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            count <= '0;
        else if (o_load)
            count <= '0;
        else if (step)
            count <= count + 32'd1;
    end

endmodule

/* design/cfg_ctrl.sv */
// Command decode, read responses, back-pressure and config management sequencer

`timescale 1ns/1ps

module cfg_ctrl
    import pcie_cfg_pkg::*;
(
    input  logic       clk_pcie,
    input  logic       rst,
    input  logic       i_cmd_valid,
    input  cmd_word_t  i_cmd_data,
    input  logic       i_rsp_full,
    input  word16_t    i_read_data,
    input  logic       i_start_rd,
    input  logic       i_start_wr,
    input  logic       i_wait_complete,
    input  logic       i_mgmt_done,
    output logic       o_cmd_ready,
    output logic       o_rsp_valid,
    output rsp_word_t  o_rsp_data,
    output byte_addr_t o_read_addr,
    output logic       o_wr_strobe,
    output byte_addr_t o_wr_addr,
    output word16_t    o_wr_mask,
    output word16_t    o_wr_value,
    output logic       o_clear_rd_start,
    output logic       o_clear_wr_start,
    output logic       o_mgmt_rd_en,
    output logic       o_mgmt_wr_en,
    output logic       o_capture,
    output logic       o_idle
);

    mgmt_state_t state;
    mgmt_state_t state_nxt;
    logic        cmd_accept;
    logic        rd_accept;
    byte_addr_t  cmd_addr;
    logic        mgmt_pending;

    // ------------------------------
    // Command decode
    // ------------------------------
    assign cmd_addr     = i_cmd_data[31:16];
    assign mgmt_pending = i_start_rd | i_start_wr | (state != IDLE);
    assign o_cmd_ready  = ~i_rsp_full & ~(i_wait_complete & mgmt_pending);
    assign cmd_accept   = i_cmd_valid & o_cmd_ready;
    assign rd_accept    = cmd_accept & i_cmd_data[CMD_BIT_RD];

    assign o_read_addr = cmd_addr;
    assign o_wr_addr   = cmd_addr;
    assign o_wr_strobe = cmd_accept & i_cmd_data[CMD_BIT_WR] & cmd_addr[ADDR_BIT_RW_MAP];
    assign o_wr_mask   = {i_cmd_data[39:32], i_cmd_data[47:40]};   // Undo byte swap
    assign o_wr_value  = {i_cmd_data[55:48], i_cmd_data[63:56]};

    // Response one cycle after the read
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            o_rsp_valid <= 1'b0;
        else
            o_rsp_valid <= rd_accept;
    end

    always_ff @(posedge clk_pcie)
    begin
        if (rd_accept)
            o_rsp_data <= {cmd_addr, i_read_data[7:0], i_read_data[15:8]};
    end

    // ------------------------------
    // Management sequencer
    // ------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (i_start_rd)     // Read goes first when both are set
                    state_nxt = READ;
                else if (i_start_wr)
                    state_nxt = WRITE;
            end
            READ, WRITE:
            begin
                if (i_mgmt_done)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    assign o_clear_rd_start = (state == IDLE) & i_start_rd;
    assign o_clear_wr_start = (state == IDLE) & ~i_start_rd & i_start_wr;

    // Enables drop in the done cycle itself
    assign o_mgmt_rd_en = (state == READ) & ~i_mgmt_done;
    assign o_mgmt_wr_en = (state == WRITE) & ~i_mgmt_done;
    assign o_capture    = (state != IDLE) & i_mgmt_done;

    assign o_idle = ~cmd_accept & ~mgmt_pending;   // Gates the auto-clear counter

endmodule

/* design/pcie_cfg_top.sv */
// Configuration register block top level with control, maps and auto-clear timer

`timescale 1ns/1ps

module pcie_cfg_top
    import pcie_cfg_pkg::*;
#(
    parameter dword_t CLEAR_INTERVAL = CLEAR_INTERVAL_DEFAULT
)
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  cmd_word_t   i_cmd_data,
    input  logic        i_rsp_full,
    input  logic        i_mgmt_done,
    input  dword_t      i_mgmt_do,
    input  word16_t     i_func_id,
    input  word16_t     i_link_status,
    output logic        o_cmd_ready,
    output logic        o_rsp_valid,
    output rsp_word_t   o_rsp_data,
    output logic        o_mgmt_rd_en,
    output logic        o_mgmt_wr_en,
    output dword_t      o_mgmt_di,
    output dwaddr_t     o_mgmt_dwaddr,
    output byte_en_t    o_mgmt_byte_en,
    output logic        o_mgmt_wr_readonly,
    output logic        o_mgmt_wr_rw1c,
    output logic [63:0] o_dsn
);

    // ------------------------------
    // Internal connections
    // ------------------------------
    logic [RW_MAP_BITS-1:0] rw_map;
    byte_addr_t             read_addr;
    word16_t                read_data;
    logic                   wr_strobe;
    byte_addr_t             wr_addr;
    word16_t                wr_mask;
    word16_t                wr_value;
    logic                   clear_rd_start;
    logic                   clear_wr_start;
    logic                   clear_load;
    logic                   start_rd;
    logic                   start_wr;
    logic                   wait_complete;
    logic                   clear_en;
    dword_t                 clear_interval;
    logic                   capture;
    logic                   idle;

    cfg_ctrl cfg_ctrl_i (
        .clk_pcie         (clk_pcie),
        .rst              (rst),
        .i_cmd_valid      (i_cmd_valid),
        .i_cmd_data       (i_cmd_data),
        .i_rsp_full       (i_rsp_full),
        .i_read_data      (read_data),
        .i_start_rd       (start_rd),
        .i_start_wr       (start_wr),
        .i_wait_complete  (wait_complete),
        .i_mgmt_done      (i_mgmt_done),
        .o_cmd_ready      (o_cmd_ready),
        .o_rsp_valid      (o_rsp_valid),
        .o_rsp_data       (o_rsp_data),
        .o_read_addr      (read_addr),
        .o_wr_strobe      (wr_strobe),
        .o_wr_addr        (wr_addr),
        .o_wr_mask        (wr_mask),
        .o_wr_value       (wr_value),
        .o_clear_rd_start (clear_rd_start),
        .o_clear_wr_start (clear_wr_start),
        .o_mgmt_rd_en     (o_mgmt_rd_en),
        .o_mgmt_wr_en     (o_mgmt_wr_en),
        .o_capture        (capture),
        .o_idle           (idle)
    );

    cfg_rw_regs #(
        .CLEAR_INTERVAL (CLEAR_INTERVAL)
    ) cfg_rw_regs_i (
        .clk_pcie           (clk_pcie),
        .rst                (rst),
        .i_wr_strobe        (wr_strobe),
        .i_wr_addr          (wr_addr),
        .i_wr_mask          (wr_mask),
        .i_wr_value         (wr_value),
        .i_clear_rd_start   (clear_rd_start),
        .i_clear_wr_start   (clear_wr_start),
        .i_clear_load       (clear_load),
        .o_rw_map           (rw_map),
        .o_start_rd         (start_rd),
        .o_start_wr         (start_wr),
        .o_wait_complete    (wait_complete),
        .o_clear_en         (clear_en),
        .o_clear_interval   (clear_interval),
        .o_dsn              (o_dsn),
        .o_mgmt_di          (o_mgmt_di),
        .o_mgmt_dwaddr      (o_mgmt_dwaddr),
        .o_mgmt_wr_readonly (o_mgmt_wr_readonly),
        .o_mgmt_wr_rw1c     (o_mgmt_wr_rw1c),
        .o_mgmt_byte_en     (o_mgmt_byte_en)
    );

    cfg_ro_status cfg_ro_status_i (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .i_rw_map       (rw_map),
        .i_read_addr    (read_addr),
        .i_func_id      (i_func_id),
        .i_link_status  (i_link_status),
        .i_mgmt_rd_en   (o_mgmt_rd_en),
        .i_mgmt_wr_en   (o_mgmt_wr_en),
        .i_mgmt_do      (i_mgmt_do),
        .i_capture      (capture),
        .i_mgmt_dwaddr  (o_mgmt_dwaddr),   // Captured with the result
        .i_mgmt_byte_en (o_mgmt_byte_en),
        .o_read_data    (read_data)
    );

    cfg_status_clear cfg_status_clear_i (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .i_enable   (clear_en),
        .i_idle     (idle),
        .i_interval (clear_interval),
        .o_load     (clear_load)
    );

endmodule

/* verification/pcie_cfg_asserts.sv */
// Concurrent checks on the management handshake and read response timing, bound to cfg_ctrl

`timescale 1ns/1ps

module pcie_cfg_asserts
    import pcie_cfg_pkg::*;
(
    input logic      clk_pcie,
    input logic      rst,
    input logic      i_cmd_valid,
    input logic      i_cmd_ready,
    input cmd_word_t i_cmd_data,
    input logic      i_rsp_valid,
    input logic      i_start_rd,
    input logic      i_start_wr,
    input logic      i_mgmt_rd_en,
    input logic      i_mgmt_wr_en,
    input logic      i_mgmt_done
);

    // Launching an access consumes its start bit
    rd_start_cleared: assert property (@(posedge clk_pcie) disable iff (rst)
        $rose(i_mgmt_rd_en) |-> !i_start_rd)
        else $error("Read start bit still set after the read enable rose");

    wr_start_cleared: assert property (@(posedge clk_pcie) disable iff (rst)
        $rose(i_mgmt_wr_en) |-> !i_start_wr)
        else $error("Write start bit still set after the write enable rose");

    rsp_after_read: assert property (@(posedge clk_pcie) disable iff (rst)
        i_cmd_valid && i_cmd_ready && i_cmd_data[CMD_BIT_RD] |=> i_rsp_valid)
        else $error("No response valid one cycle after an accepted read");

    // Done only answers an enable seen in the previous cycle
    done_follows_enable: assert property (@(posedge clk_pcie) disable iff (rst)
        i_mgmt_done |-> $past(i_mgmt_rd_en || i_mgmt_wr_en))
        else $error("Management done without an active enable");

endmodule

bind cfg_ctrl pcie_cfg_asserts asserts_i (
    .clk_pcie     (clk_pcie),
    .rst          (rst),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_ready  (o_cmd_ready),
    .i_cmd_data   (i_cmd_data),
    .i_rsp_valid  (o_rsp_valid),
    .i_start_rd   (i_start_rd),
    .i_start_wr   (i_start_wr),
    .i_mgmt_rd_en (o_mgmt_rd_en),
    .i_mgmt_wr_en (o_mgmt_wr_en),
    .i_mgmt_done  (i_mgmt_done)
);

/* verification/pcie_cfg_tb.sv */
// Testbench with clock, reset, management core model, stimulus table and checks

`timescale 1ns/1ps

module pcie_cfg_tb;

    typedef enum {OP_READ, OP_WRITE, OP_RAND_WRITE, OP_MGMT_READ, OP_WAIT_COMPLETE,
                  OP_AUTO_CLEAR, OP_BACKPRESSURE} op_t;

    logic        clk_pcie = 1'b0;
    logic        rst = 1'b1;
    logic        i_cmd_valid = 1'b0;
    logic [63:0] i_cmd_data = '0;
    logic        i_rsp_full = 1'b0;
    logic        i_mgmt_done = 1'b0;
    logic [31:0] i_mgmt_do = '0;
    logic [15:0] i_func_id = 16'hA5C3;
    logic [15:0] i_link_status = 16'h1234;
    logic        o_cmd_ready;
    logic        o_rsp_valid;
    logic [31:0] o_rsp_data;
    logic        o_mgmt_rd_en;
    logic        o_mgmt_wr_en;
    logic [31:0] o_mgmt_di;
    logic [9:0]  o_mgmt_dwaddr;
    logic [3:0]  o_mgmt_byte_en;
    logic        o_mgmt_wr_readonly;
    logic        o_mgmt_wr_rw1c;
    logic [63:0] o_dsn;

    // Stimulus table columns
    string       t_name[$];
    op_t         t_op[$];
    logic [15:0] t_addr[$];
    logic [15:0] t_mask[$];
    logic [15:0] t_value[$];
    logic [31:0] t_exp[$];

    logic [31:0] seed = 32'h6d22_68de;
    logic [15:0] shadow_8010 = 16'h0000;   // MGMT_DI low word, zero after reset
    logic        run_ended = 1'b0;
    int          done_wait = 0;
    int          cycle_count = 0;

    pcie_cfg_top #(
        .CLEAR_INTERVAL (32'd40)
    ) pcie_cfg_top_i (.*);

    always #5 clk_pcie = ~clk_pcie;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] swap16(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    function automatic logic [63:0] make_cmd(input logic rd, input logic wr,
                                             input logic [15:0] addr, input logic [15:0] mask,
                                             input logic [15:0] value);
        return {swap16(value), swap16(mask), addr, 2'b00, wr, rd, 12'h000};
    endfunction

    function automatic void add_entry(input string name, input op_t op, input logic [15:0] addr,
                                      input logic [15:0] mask, input logic [15:0] value,
                                      input logic [31:0] exp_rsp);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_mask.push_back(mask);
        t_value.push_back(value);
        t_exp.push_back(exp_rsp);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            run_ended = 1'b1;
            $display("TB FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_pcie);
        #1;     // Drive point
    endtask

    task automatic send_cmd(input logic rd, input logic wr, input logic [15:0] addr,
                            input logic [15:0] mask, input logic [15:0] value);
        while (!o_cmd_ready)
            next_cycle();
        i_cmd_valid = 1'b1;
        i_cmd_data  = make_cmd(rd, wr, addr, mask, value);
        next_cycle();
        i_cmd_valid = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [15:0] addr,
                              input logic [31:0] exp_rsp);
        send_cmd(1'b1, 1'b0, addr, 16'h0000, 16'h0000);
        @(negedge clk_pcie);
        check_value({name, " rsp_valid"}, 32'd1, 32'(o_rsp_valid));
        check_value(name, exp_rsp, o_rsp_data);
        next_cycle();
    endtask

    // ------------------------------
    // Management core model
    // ------------------------------
    always @(posedge clk_pcie)
    begin
        #1;
        if (rst || i_mgmt_done)
        begin
            i_mgmt_done = 1'b0;
            done_wait   = 0;
        end
        else if (o_mgmt_rd_en || o_mgmt_wr_en)
        begin
            done_wait = done_wait + 1;
            if (done_wait == 3)
            begin
                i_mgmt_done = 1'b1;
                i_mgmt_do   = 32'hC0DE0000 + 32'(o_mgmt_dwaddr);
            end
        end
    end

    // Watchdog, 40 cycles per table entry plus setup
    always @(posedge clk_pcie)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 40 * t_name.size() + 200)
        begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            run_ended = 1'b1;
            $display("TB FAILED");
            $fatal(1, "Simulation stopped by the watchdog");
        end
    end

    final
    begin
        if (!run_ended)
            $display("TB FAILED");
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial
    begin
        logic [15:0] rand_mask;
        logic [15:0] rand_value;

        add_entry("ro_magic",      OP_READ,          16'h0000, 16'h0000, 16'h0000, 32'h00000123);
        add_entry("rw_magic",      OP_READ,          16'h8000, 16'h0000, 16'h0000, 32'h80004567);
        add_entry("ro_byte_count", OP_READ,          16'h0004, 16'h0000, 16'h0000, 32'h00041800);
        add_entry("rw_byte_count", OP_READ,          16'h8004, 16'h0000, 16'h0000, 32'h80042000);
        add_entry("func_id",       OP_READ,          16'h0008, 16'h0000, 16'h0000, 32'h0008C3A5);
        add_entry("link_status",   OP_READ,          16'h000A, 16'h0000, 16'h0000, 32'h000A3412);
        add_entry("rand_write_0",  OP_RAND_WRITE,    16'h8010, 16'h0000, 16'h0000, 32'h0);
        add_entry("rand_write_1",  OP_RAND_WRITE,    16'h8010, 16'h0000, 16'h0000, 32'h0);
        add_entry("rand_write_2",  OP_RAND_WRITE,    16'h8010, 16'h0000, 16'h0000, 32'h0);
        add_entry("ro_write",      OP_WRITE,         16'h0000, 16'hFFFF, 16'h0000, 32'h0);
        add_entry("rw_write_end",  OP_WRITE,         16'h8020, 16'hFFFF, 16'h1234, 32'h0);
        add_entry("rw_untouched",  OP_READ,          16'h8000, 16'h0000, 16'h0000, 32'h80004567);
        add_entry("ro_beyond",     OP_READ,          16'h0018, 16'h0000, 16'h0000, 32'h00180000);
        add_entry("rw_beyond",     OP_READ,          16'h8020, 16'h0000, 16'h0000, 32'h80200000);
        add_entry("dwaddr",        OP_WRITE,         16'h8014, 16'h0FFF, 16'h0C05, 32'h0);
        add_entry("mgmt_read",     OP_MGMT_READ,     16'h8002, 16'h0001, 16'h0001, 32'h0);
        add_entry("rb_word",       OP_READ,          16'h0010, 16'h0000, 16'h0000, 32'h001005F8);
        add_entry("rb_data_lo",    OP_READ,          16'h0014, 16'h0000, 16'h0000, 32'h00140500);
        add_entry("rb_data_hi",    OP_READ,          16'h0016, 16'h0000, 16'h0000, 32'h0016DEC0);
        add_entry("wait_complete", OP_WAIT_COMPLETE, 16'h8002, 16'h0005, 16'h0005, 32'h0);
        add_entry("wait_off",      OP_WRITE,         16'h8002, 16'h0004, 16'h0000, 32'h0);
        add_entry("auto_clear",    OP_AUTO_CLEAR,    16'h8002, 16'h0008, 16'h0008, 32'h0);
        add_entry("clear_off",     OP_WRITE,         16'h8002, 16'h0008, 16'h0000, 32'h0);
        add_entry("backpressure",  OP_BACKPRESSURE,  16'h0000, 16'h0000, 16'h0000, 32'h00000123);

        repeat (3) @(posedge clk_pcie);
        #1;
        rst = 1'b0;

        @(negedge clk_pcie);
        check_value("reset rsp_valid", 32'd0, 32'(o_rsp_valid));
        check_value("reset rd_en", 32'd0, 32'(o_mgmt_rd_en));
        check_value("reset wr_en", 32'd0, 32'(o_mgmt_wr_en));
        check_value("reset cmd_ready", 32'd1, 32'(o_cmd_ready));
        check_value("reset dsn hi", 32'h00000001, o_dsn[63:32]);
        check_value("reset dsn lo", 32'h01000A35, o_dsn[31:0]);
        next_cycle();

        for (int n = 0; n < t_name.size(); n++)
        begin
            case (t_op[n])
                OP_READ:
                    read_check(t_name[n], t_addr[n], t_exp[n]);
                OP_WRITE:
                    send_cmd(1'b0, 1'b1, t_addr[n], t_mask[n], t_value[n]);
                OP_RAND_WRITE:
                begin
                    seed        = xorshift32(seed);
                    rand_mask   = seed[15:0];
                    rand_value  = seed[31:16];
                    shadow_8010 = (shadow_8010 & ~rand_mask) | (rand_value & rand_mask);
                    send_cmd(1'b0, 1'b1, t_addr[n], rand_mask, rand_value);
                    read_check(t_name[n], t_addr[n], {t_addr[n], swap16(shadow_8010)});
                end
                OP_MGMT_READ:
                begin
                    send_cmd(1'b0, 1'b1, t_addr[n], t_mask[n], t_value[n]);
                    do @(negedge clk_pcie); while (!o_mgmt_rd_en);
                    do @(negedge clk_pcie); while (!i_mgmt_done);
                    check_value({t_name[n], " rd_en in done"}, 32'd0, 32'(o_mgmt_rd_en));
                    next_cycle();
                end
                OP_WAIT_COMPLETE:
                begin
                    send_cmd(1'b0, 1'b1, t_addr[n], t_mask[n], t_value[n]);
                    @(negedge clk_pcie);
                    while (!i_mgmt_done)
                    begin
                        check_value({t_name[n], " ready low"}, 32'd0, 32'(o_cmd_ready));
                        @(negedge clk_pcie);
                    end
                    @(negedge clk_pcie);     // First cycle after done
                    check_value({t_name[n], " ready back"}, 32'd1, 32'(o_cmd_ready));
                    next_cycle();
                end
                OP_AUTO_CLEAR:
                begin
                    // Both flags were set by the dwaddr write
                    check_value({t_name[n], " readonly set"}, 32'd1, 32'(o_mgmt_wr_readonly));
                    check_value({t_name[n], " rw1c set"}, 32'd1, 32'(o_mgmt_wr_rw1c));
                    send_cmd(1'b0, 1'b1, t_addr[n], t_mask[n], t_value[n]);
                    do @(negedge clk_pcie); while (!o_mgmt_wr_en);
                    check_value({t_name[n], " di"}, 32'hFF000000, o_mgmt_di);
                    check_value({t_name[n], " dwaddr"}, 32'd1, 32'(o_mgmt_dwaddr));
                    check_value({t_name[n], " byte_en"}, 32'h8, 32'(o_mgmt_byte_en));
                    check_value({t_name[n], " readonly"}, 32'd0, 32'(o_mgmt_wr_readonly));
                    check_value({t_name[n], " rw1c"}, 32'd0, 32'(o_mgmt_wr_rw1c));
                    do @(negedge clk_pcie); while (!i_mgmt_done);
                    next_cycle();
                end
                OP_BACKPRESSURE:
                begin
                    i_rsp_full = 1'b1;
                    repeat (3)
                    begin
                        @(negedge clk_pcie);
                        check_value({t_name[n], " ready low"}, 32'd0, 32'(o_cmd_ready));
                    end
                    next_cycle();
                    i_rsp_full = 1'b0;
                    read_check(t_name[n], t_addr[n], t_exp[n]);
                end
                default:
                    check_value("unknown table operation", 32'd0, 32'd1);
            endcase
        end

        run_ended = 1'b1;
        $display("TB PASSED");
        $finish;
    end

endmodule

/* files.f */
design/pcie_cfg_pkg.sv
design/cfg_rw_regs.sv
design/cfg_ro_status.sv
design/cfg_status_clear.sv
design/cfg_ctrl.sv
design/pcie_cfg_top.sv
verification/pcie_cfg_asserts.sv
verification/pcie_cfg_tb.sv

/* Makefile */
TOP = pcie_cfg_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
